//--- logic/blackjack_pkg.sv
// Blackjack shared types and helpers
package blackjack_pkg;

    typedef logic [3:0]  card_t;   // 1 to 10 where 1 is an ace
    typedef logic [4:0]  score_t;
    typedef logic [3:0]  digit_t;
    typedef logic [6:0]  seg_t;    // Active low with bit 0 as segment a
    typedef logic [15:0] lfsr_t;

    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_dealing = 3'd1,
        st_player  = 3'd2,
        st_dealer  = 3'd3,
        st_over    = 3'd4
    } game_state_t;

    typedef struct packed {
        score_t score;
        logic   visible;
    } hand_view_t;

    localparam score_t      blackjack_score    = 5'd21;
    localparam score_t      dealer_stand_score = 5'd17;
    localparam score_t      ace_high_bonus     = 5'd10;
    localparam lfsr_t       lfsr_seed          = 16'hACE1;
    localparam int unsigned initial_cards      = 4;

    // Status letters
    localparam seg_t seg_blank = 7'b1111111;
    localparam seg_t seg_p     = 7'b0001100;
    localparam seg_t seg_d     = 7'b0100001;
    localparam seg_t seg_b     = 7'b0000011;
    localparam seg_t seg_tie   = 7'b0001111;

    // State numbers shown on the last display
    localparam seg_t seg_state_1 = 7'b1111001;
    localparam seg_t seg_state_2 = 7'b0100100;
    localparam seg_t seg_state_3 = 7'b0110000;
    localparam seg_t seg_state_4 = 7'b0011001;
    localparam seg_t seg_state_5 = 7'b0010010;

    function automatic seg_t digit_to_seg(digit_t digit);
        case (digit)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // New hand total after one more card
    function automatic score_t add_card(score_t score, card_t card, logic has_ace);
        logic [5:0] sum;
        sum = {1'b0, score} + {2'b00, card};
        if (card == 4'd1) begin
            if (score <= ace_high_bonus)
                return score + ace_high_bonus + 5'd1;  // Ace counts 11
            return score + 5'd1;
        end
        // Earlier ace drops from 11 to 1 on every overflowing card
        if (has_ace && (sum > 6'(blackjack_score)))
            return score_t'(sum - 6'(ace_high_bonus));
        return score_t'(sum);
    endfunction

endpackage

//--- logic/card_rng.sv
// LFSR card source
`timescale 1ns/100ps

module card_rng (
    input  logic                 clk,
    input  logic                 rst_n,
    output blackjack_pkg::card_t card
);

    blackjack_pkg::lfsr_t lfsr;
    blackjack_pkg::card_t next_card;
    logic                 feedback;

    // Taps 15, 14, 12, 3
    assign feedback = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

    // Nibble pairs give 1 to 6, the top four nibbles give 7 to 10
    always_comb begin
        if (lfsr[3:0] < 4'd12)
            next_card = {1'b0, lfsr[3:1]} + 4'd1;
        else
            next_card = lfsr[3:0] - 4'd5;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= blackjack_pkg::lfsr_seed;
            card <= 4'd1;
        end else begin
            lfsr <= {lfsr[14:0], feedback};
            card <= next_card;
        end
    end

endmodule

//--- logic/key_debouncer.sv
// Key press debouncer
`timescale 1ns/100ps

module key_debouncer #(
    parameter int unsigned debounce_cycles = 1 << 20
) (
    input  logic clk,
    input  logic rst_n,
    input  logic key,
    output logic press
);

    localparam int unsigned count_width = $clog2(debounce_cycles + 1);
    localparam logic [count_width-1:0] count_max = count_width'(debounce_cycles);

    logic [count_width-1:0] count;
    logic                   fired;   // Pulse already given for this hold

    assign press = (count == count_max) && !fired;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            fired <= 1'b0;
        end else if (!key) begin
            // Release rearms
            count <= '0;
            fired <= 1'b0;
        end else if (count != count_max) begin
            count <= count + 1'b1;
        end else begin
            fired <= 1'b1;           // Saturated, hold until release
        end
    end

endmodule

//--- logic/hand_scorer.sv
// Single hand score keeper
`timescale 1ns/100ps

module hand_scorer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  new_round,
    input  logic                  draw,
    input  blackjack_pkg::card_t  card,
    output blackjack_pkg::score_t score,
    output logic                  has_ace
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score   <= '0;
            has_ace <= 1'b0;
        end else if (new_round) begin
            score   <= '0;
            has_ace <= 1'b0;
        end else if (draw) begin
            score <= blackjack_pkg::add_card(score, card, has_ace);
            if (card == 4'd1)
                has_ace <= 1'b1;    // Sticky until next round
        end
    end

endmodule

//--- logic/blackjack_fsm.sv
// Blackjack round controller
`timescale 1ns/100ps

module blackjack_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        hit_press,
    input  logic                        stand_press,
    input  logic                        deal_press,
    input  blackjack_pkg::card_t        card,
    input  blackjack_pkg::score_t       player_score,
    input  blackjack_pkg::score_t       dealer_score,
    input  logic                        player_has_ace,
    input  logic                        dealer_has_ace,
    output logic                        player_draw,
    output logic                        dealer_draw,
    output logic                        new_round,
    output logic                        dealer_visible,
    output blackjack_pkg::game_state_t  state
);

    localparam logic [1:0] last_deal_card = 2'(blackjack_pkg::initial_cards - 1);

    blackjack_pkg::game_state_t next_state;
    blackjack_pkg::score_t      player_next;
    blackjack_pkg::score_t      dealer_next;
    logic [1:0]                 deal_cnt;
    logic                       deal_done;
    logic                       dealing;
    logic                       natural;
    logic                       dealer_short;

    // Totals the hands will hold if they take the current card
    assign player_next = blackjack_pkg::add_card(player_score, card, player_has_ace);
    assign dealer_next = blackjack_pkg::add_card(dealer_score, card, dealer_has_ace);

    assign dealing      = (state == blackjack_pkg::st_dealing) && !deal_done;
    assign dealer_short = dealer_score < blackjack_pkg::dealer_stand_score;
    assign natural      = (player_score == blackjack_pkg::blackjack_score) ||
                          (dealer_score == blackjack_pkg::blackjack_score);

    assign new_round = (state == blackjack_pkg::st_idle) && deal_press;

    // Deal order is player, dealer, player, dealer
    assign player_draw = (dealing && !deal_cnt[0]) ||
                         ((state == blackjack_pkg::st_player) && hit_press);
    assign dealer_draw = (dealing && deal_cnt[0]) ||
                         ((state == blackjack_pkg::st_dealer) && dealer_short);

    always_comb begin
        next_state = state;
        case (state)
            blackjack_pkg::st_idle: begin
                if (deal_press)
                    next_state = blackjack_pkg::st_dealing;
            end
            blackjack_pkg::st_dealing: begin
                if (deal_done)   // Decision cycle after the fourth card
                    next_state = natural ? blackjack_pkg::st_over : blackjack_pkg::st_player;
            end
            blackjack_pkg::st_player: begin
                if (hit_press) begin
                    if (player_next > blackjack_pkg::blackjack_score)
                        next_state = blackjack_pkg::st_over;   // Bust
                end else if (stand_press) begin
                    next_state = blackjack_pkg::st_dealer;
                end
            end
            blackjack_pkg::st_dealer: begin
                // Leave on the edge of the card that reaches the stand score
                if (!dealer_short || (dealer_next >= blackjack_pkg::dealer_stand_score))
                    next_state = blackjack_pkg::st_over;
            end
            blackjack_pkg::st_over: begin
                if (deal_press)
                    next_state = blackjack_pkg::st_idle;
            end
            default: next_state = blackjack_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= blackjack_pkg::st_idle;
            deal_cnt       <= '0;
            deal_done      <= 1'b0;
            dealer_visible <= 1'b0;
        end else begin
            state <= next_state;
            if (new_round) begin
                deal_cnt       <= '0;
                deal_done      <= 1'b0;
                dealer_visible <= 1'b0;
            end else begin
                if (dealing) begin
                    deal_cnt <= deal_cnt + 2'd1;
                    if (deal_cnt == last_deal_card)
                        deal_done <= 1'b1;
                end
                if (dealer_draw)
                    dealer_visible <= 1'b1;   // Shown from the first dealer card
            end
        end
    end

endmodule

//--- logic/score_display.sv
// Score and status display decode
`timescale 1ns/100ps

module score_display (
    input  blackjack_pkg::hand_view_t  player,
    input  blackjack_pkg::hand_view_t  dealer,
    input  blackjack_pkg::game_state_t state,
    output blackjack_pkg::seg_t        hex_player_ones,
    output blackjack_pkg::seg_t        hex_player_tens,
    output blackjack_pkg::seg_t        hex_dealer_ones,
    output blackjack_pkg::seg_t        hex_dealer_tens,
    output blackjack_pkg::seg_t        hex_status,
    output blackjack_pkg::seg_t        hex_state
);

    blackjack_pkg::score_t player_shown;
    blackjack_pkg::score_t dealer_shown;
    blackjack_pkg::seg_t   outcome;

    // Hidden hand reads as zero
    assign player_shown = player.visible ? player.score : '0;
    assign dealer_shown = dealer.visible ? dealer.score : '0;

    assign hex_player_ones = blackjack_pkg::digit_to_seg(4'(player_shown % 5'd10));
    assign hex_player_tens = blackjack_pkg::digit_to_seg(4'(player_shown / 5'd10));
    assign hex_dealer_ones = blackjack_pkg::digit_to_seg(4'(dealer_shown % 5'd10));
    assign hex_dealer_tens = blackjack_pkg::digit_to_seg(4'(dealer_shown / 5'd10));

    // Round result where the first match wins
    always_comb begin
        if (player.score > blackjack_pkg::blackjack_score)
            outcome = blackjack_pkg::seg_b;
        else if (dealer.score > blackjack_pkg::blackjack_score)
            outcome = blackjack_pkg::seg_p;
        else if (player.score == dealer.score)
            outcome = blackjack_pkg::seg_tie;
        else if (player.score > dealer.score)
            outcome = blackjack_pkg::seg_p;
        else
            outcome = blackjack_pkg::seg_d;
    end

    always_comb begin
        case (state)
            blackjack_pkg::st_idle: begin
                hex_status = blackjack_pkg::seg_blank;
                hex_state  = blackjack_pkg::seg_state_1;
            end
            blackjack_pkg::st_dealing: begin
                hex_status = blackjack_pkg::seg_d;
                hex_state  = blackjack_pkg::seg_state_2;
            end
            blackjack_pkg::st_player: begin
                hex_status = blackjack_pkg::seg_p;
                hex_state  = blackjack_pkg::seg_state_3;
            end
            blackjack_pkg::st_dealer: begin
                hex_status = blackjack_pkg::seg_d;
                hex_state  = blackjack_pkg::seg_state_4;
            end
            blackjack_pkg::st_over: begin
                hex_status = outcome;
                hex_state  = blackjack_pkg::seg_state_5;
            end
            default: begin
                hex_status = blackjack_pkg::seg_blank;
                hex_state  = blackjack_pkg::seg_blank;
            end
        endcase
    end

endmodule

//--- logic/blackjack_top.sv
// Blackjack game top level
`timescale 1ns/100ps

module blackjack_top #(
    parameter int unsigned debounce_cycles = 1 << 20
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hit,
    input  logic                stand,
    input  logic                deal,
    output blackjack_pkg::seg_t hex_player_ones,
    output blackjack_pkg::seg_t hex_player_tens,
    output blackjack_pkg::seg_t hex_dealer_ones,
    output blackjack_pkg::seg_t hex_dealer_tens,
    output blackjack_pkg::seg_t hex_status,
    output blackjack_pkg::seg_t hex_state
);

    logic                       hit_press;
    logic                       stand_press;
    logic                       deal_press;
    blackjack_pkg::card_t       card;
    blackjack_pkg::score_t      player_score;
    blackjack_pkg::score_t      dealer_score;
    logic                       player_has_ace;
    logic                       dealer_has_ace;
    logic                       player_draw;
    logic                       dealer_draw;
    logic                       new_round;
    logic                       dealer_visible;
    blackjack_pkg::game_state_t state;
    blackjack_pkg::hand_view_t  player_view;
    blackjack_pkg::hand_view_t  dealer_view;

    key_debouncer #(.debounce_cycles(debounce_cycles)) hit_deb (
        .clk(clk), .rst_n(rst_n), .key(hit), .press(hit_press)
    );
    key_debouncer #(.debounce_cycles(debounce_cycles)) stand_deb (
        .clk(clk), .rst_n(rst_n), .key(stand), .press(stand_press)
    );
    key_debouncer #(.debounce_cycles(debounce_cycles)) deal_deb (
        .clk(clk), .rst_n(rst_n), .key(deal), .press(deal_press)
    );

    card_rng card_rng_inst (.clk(clk), .rst_n(rst_n), .card(card));

    blackjack_fsm blackjack_fsm_inst (
        .clk(clk), .rst_n(rst_n),
        .hit_press(hit_press), .stand_press(stand_press), .deal_press(deal_press),
        .card(card),
        .player_score(player_score), .dealer_score(dealer_score),
        .player_has_ace(player_has_ace), .dealer_has_ace(dealer_has_ace),
        .player_draw(player_draw), .dealer_draw(dealer_draw),
        .new_round(new_round), .dealer_visible(dealer_visible), .state(state)
    );

    hand_scorer player_hand (
        .clk(clk), .rst_n(rst_n), .new_round(new_round), .draw(player_draw),
        .card(card), .score(player_score), .has_ace(player_has_ace)
    );
    hand_scorer dealer_hand (
        .clk(clk), .rst_n(rst_n), .new_round(new_round), .draw(dealer_draw),
        .card(card), .score(dealer_score), .has_ace(dealer_has_ace)
    );

    assign player_view = '{score: player_score, visible: 1'b1};   // Always shown
    assign dealer_view = '{score: dealer_score, visible: dealer_visible};

    score_display score_display_inst (
        .player(player_view), .dealer(dealer_view), .state(state),
        .hex_player_ones(hex_player_ones), .hex_player_tens(hex_player_tens),
        .hex_dealer_ones(hex_dealer_ones), .hex_dealer_tens(hex_dealer_tens),
        .hex_status(hex_status), .hex_state(hex_state)
    );

endmodule

//--- tb/blackjack_tb.sv
// Blackjack controller testbench
`timescale 1ns/100ps

module blackjack_tb;

    localparam int debounce_cycles  = 16;
    localparam int hold_cycles      = 20;
    localparam int num_rounds       = 20;
    localparam int cycles_per_round = 400;
    localparam int max_cycles       = num_rounds * cycles_per_round + 1000;

    localparam int key_hit   = 0;
    localparam int key_stand = 1;
    localparam int key_deal  = 2;

    logic                clk;
    logic                rst_n;
    logic                hit;
    logic                stand;
    logic                deal;
    blackjack_pkg::seg_t hex_player_ones;
    blackjack_pkg::seg_t hex_player_tens;
    blackjack_pkg::seg_t hex_dealer_ones;
    blackjack_pkg::seg_t hex_dealer_tens;
    blackjack_pkg::seg_t hex_status;
    blackjack_pkg::seg_t hex_state;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     prev_state;
    int     deal_len = 0;
    int     seen_b = 0;
    int     seen_p = 0;
    int     seen_d = 0;
    int     seen_t = 0;
    logic   monitor_on;

    blackjack_top #(.debounce_cycles(debounce_cycles)) blackjack_top_inst (
        .clk(clk), .rst_n(rst_n),
        .hit(hit), .stand(stand), .deal(deal),
        .hex_player_ones(hex_player_ones), .hex_player_tens(hex_player_tens),
        .hex_dealer_ones(hex_dealer_ones), .hex_dealer_tens(hex_dealer_tens),
        .hex_status(hex_status), .hex_state(hex_state)
    );

    always #10 clk = ~clk;   // 20 ns period

    // Active low glyphs back to decimal digits
    function automatic int seg_to_digit(blackjack_pkg::seg_t seg);
        case (seg)
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0010000: return 9;
            default:    return -1;
        endcase
    endfunction

    function automatic int shown_score(blackjack_pkg::seg_t tens, blackjack_pkg::seg_t ones);
        return seg_to_digit(tens) * 10 + seg_to_digit(ones);
    endfunction

    function automatic int state_now();
        return seg_to_digit(hex_state);
    endfunction

    // Result letter from the two totals where the first match wins
    function automatic blackjack_pkg::seg_t expected_status(int p, int d);
        if (p > 21)
            return blackjack_pkg::seg_b;
        if (d > 21)
            return blackjack_pkg::seg_p;
        if (p == d)
            return blackjack_pkg::seg_tie;
        if (p > d)
            return blackjack_pkg::seg_p;
        return blackjack_pkg::seg_d;
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic drive_key(input int which, input logic level);
        case (which)
            key_hit:   hit = level;
            key_stand: stand = level;
            default:   deal = level;
        endcase
    endtask

    // Hold one key and count player score changes while it is down
    task automatic press_key(input int which, input int hold, output int player_changes);
        int last;
        int now;
        player_changes = 0;
        last = shown_score(hex_player_tens, hex_player_ones);
        @(posedge clk);
        #2;
        drive_key(which, 1'b1);
        repeat (hold) begin
            @(negedge clk);
            now = shown_score(hex_player_tens, hex_player_ones);
            if (now != last)
                player_changes++;
            last = now;
            @(posedge clk);
        end
        #2;
        drive_key(which, 1'b0);
    endtask

    task automatic wait_while_state(input int n);
        while (state_now() == n)
            @(negedge clk);
    endtask

    // Per cycle display checks
    always @(negedge clk) begin : monitor
        int cur;
        int p;
        int d;
        if (monitor_on) begin
            cur = state_now();
            p = shown_score(hex_player_tens, hex_player_ones);
            d = shown_score(hex_dealer_tens, hex_dealer_ones);
            check(cur >= 1 && cur <= 5, "state glyph is not a number from 1 to 5");
            check(seg_to_digit(hex_player_tens) >= 0 && seg_to_digit(hex_player_ones) >= 0 &&
                  seg_to_digit(hex_dealer_tens) >= 0 && seg_to_digit(hex_dealer_ones) >= 0,
                  "score glyph is not a decimal digit");
            case (cur)
                1: check(hex_status == blackjack_pkg::seg_blank, "status not blank in idle");
                2, 4: check(hex_status == blackjack_pkg::seg_d, "status not d while dealer acts");
                3: check(hex_status == blackjack_pkg::seg_p, "status not P in player turn");
                5: check(hex_status == expected_status(p, d),
                         $sformatf("outcome glyph %b for player %0d dealer %0d",
                                   hex_status, p, d));
                default: ;
            endcase
            if (cur == 2) begin
                deal_len = (prev_state == 2) ? deal_len + 1 : 1;
            end else if (prev_state == 2) begin
                check(deal_len == 5, $sformatf("deal lasted %0d cycles", deal_len));
                check(cur == 3 || cur == 5, $sformatf("deal ended in state %0d", cur));
                check(d > 0, "dealer digits still zero after the deal");
                if (cur == 5)
                    check(p == 21 || d == 21,
                          $sformatf("deal ended the round at %0d / %0d", p, d));
            end
            if (prev_state == 3 && cur == 3)
                check(p <= 21, $sformatf("player at %0d still in turn", p));
            if (prev_state == 3 && cur == 5)
                check(p > 21, $sformatf("player turn ended at %0d without bust", p));
            if (prev_state == 4 && cur == 5)
                check(d >= 17, $sformatf("dealer stopped at %0d", d));
            if (cur == 5 && prev_state != 5) begin   // Tally outcomes once per round
                if (hex_status == blackjack_pkg::seg_b)
                    seen_b++;
                else if (hex_status == blackjack_pkg::seg_tie)
                    seen_t++;
                else if (hex_status == blackjack_pkg::seg_p)
                    seen_p++;
                else
                    seen_d++;
            end
            prev_state = cur;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: no finish after %0d cycles", max_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int changes;
        int choice;
        int p;
        int s;
        seed = 32'h9797b131;
        clk = 1'b0;
        rst_n = 1'b0;
        hit = 1'b0;
        stand = 1'b0;
        deal = 1'b0;
        monitor_on = 1'b0;
        prev_state = 1;

        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check(state_now() == 1, "state glyph not 1 after reset");
        check(hex_status == blackjack_pkg::seg_blank, "status not blank after reset");
        check(shown_score(hex_player_tens, hex_player_ones) == 0 &&
              shown_score(hex_dealer_tens, hex_dealer_ones) == 0,
              "score digits not zero after reset");
        monitor_on = 1'b1;

        // Too short to pass the debouncer
        press_key(key_deal, debounce_cycles - 6, changes);
        repeat (debounce_cycles + 4) @(negedge clk);
        check(state_now() == 1, "short deal pulse left idle");

        for (int round = 0; round < num_rounds; round++) begin
            press_key(key_deal, hold_cycles, changes);
            @(negedge clk);
            check(state_now() == 2, $sformatf("round %0d did not enter the deal", round));
            wait_while_state(2);
            while (state_now() == 3) begin
                choice = $random(seed) & 1;
                if (choice == 1) begin
                    press_key(key_hit, hold_cycles, changes);
                    @(negedge clk);
                    p = shown_score(hex_player_tens, hex_player_ones);
                    s = state_now();
                    check(changes <= 1, $sformatf("one hit press drew %0d times", changes));
                    check(p >= 2 && p <= 31, $sformatf("player score %0d after hit", p));
                    check(s == 3 || s == 5, $sformatf("state %0d after hit", s));
                    check((s == 5) == (p > 21),
                          $sformatf("state %0d does not match player score %0d", s, p));
                end else begin
                    press_key(key_stand, hold_cycles, changes);
                    @(negedge clk);
                    wait_while_state(4);
                end
            end
            check(state_now() == 5, $sformatf("round %0d did not reach game over", round));
            press_key(key_deal, hold_cycles, changes);   // Back to idle
            @(negedge clk);
            check(state_now() == 1, "deal press in game over did not return to idle");
        end

        $display("errors: %0d in %0d checks, outcomes b=%0d P=%0d d=%0d t=%0d",
                 errors, checks, seen_b, seen_p, seen_d, seen_t);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
logic/blackjack_pkg.sv
logic/card_rng.sv
logic/key_debouncer.sv
logic/hand_scorer.sv
logic/blackjack_fsm.sv
logic/score_display.sv
logic/blackjack_top.sv
tb/blackjack_tb.sv
